// File: design/elevator_consts.svh
`ifndef ELEVATOR_CONSTS_SVH
`define ELEVATOR_CONSTS_SVH

//////////////////////////////////////////////////
// Building geometry
//////////////////////////////////////////////////

// Floors served by the car, floor 1 is index 0
`define NUM_FLOORS 11

// Bits needed to hold one floor index
`define FLOOR_W 4

//////////////////////////////////////////////////
// Reset values
//////////////////////////////////////////////////

// Direction the scheduler starts out with, 1 means up
`define RESET_DIR_UP 1'b1

`endif

// File: design/elevator_pkg.sv
`include "elevator_consts.svh"

package elevator_pkg;

    //////////////////////////////////////////////////
    // Floor related types
    //////////////////////////////////////////////////

    // Floor index, 0 is the ground floor
    typedef logic [`FLOOR_W-1:0] floor_t;

    // One request bit per floor
    typedef logic [`NUM_FLOORS-1:0] floor_mask_t;

    //////////////////////////////////////////////////
    // Travel direction
    //////////////////////////////////////////////////

    typedef enum logic {
        DIR_DOWN = 1'b0,
        DIR_UP   = 1'b1
    } direction_t;

endpackage

// File: design/car_status_if.sv
interface car_status_if;
    import elevator_pkg::*;

    // Floor the car currently reports
    floor_t current_floor;
    // Car at rest with power applied
    logic   stopped;
    // Buttons may be latched
    logic   requests_enabled;
    // A new command may be issued
    logic   dispatch_enabled;

    modport source (
        output current_floor,
        output stopped,
        output requests_enabled,
        output dispatch_enabled
    );

    modport request_sink (
        input current_floor,
        input stopped,
        input requests_enabled
    );

    modport dispatch_sink (
        input current_floor,
        input dispatch_enabled
    );

endinterface

// File: design/service_gate.sv
module service_gate (
    input  logic                  clock,
    input  logic                  reset_n,
    input  logic                  power_switch,
    input  logic                  emergency_btn,
    input  logic                  elevator_moving,
    input  logic                  door_open_btn,
    input  logic                  door_close_btn,
    input  elevator_pkg::floor_t  current_floor,
    car_status_if.source          status,
    output logic                  door_open_allowed,
    output logic                  door_close_allowed
);

    logic stopped;
    logic requests_enabled;

    //////////////////////////////////////////////////
    // Service enables
    //////////////////////////////////////////////////

    // A car without power counts as not stopped
    assign stopped          = power_switch && !elevator_moving;
    assign requests_enabled = power_switch && !emergency_btn;

    assign status.current_floor    = current_floor;
    assign status.stopped          = stopped;
    assign status.requests_enabled = requests_enabled;
    assign status.dispatch_enabled = requests_enabled && stopped;

    //////////////////////////////////////////////////
    // Door permits
    //////////////////////////////////////////////////

    // Open has priority when both buttons are held
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            door_open_allowed  <= 1'b0;
            door_close_allowed <= 1'b0;
        end else begin
            door_open_allowed  <= stopped && door_open_btn;
            door_close_allowed <= stopped && door_close_btn && !door_open_btn;
        end
    end

endmodule

// File: design/floor_request_latch.sv
module floor_request_latch (
    input  logic                       clock,
    input  logic                       reset_n,
    car_status_if.request_sink         status,
    input  elevator_pkg::floor_mask_t  floor_call_buttons,
    input  elevator_pkg::floor_mask_t  panel_buttons,
    output elevator_pkg::floor_mask_t  call_button_lights,
    output elevator_pkg::floor_mask_t  panel_button_lights
);
    import elevator_pkg::*;

    // One-hot position of the car
    floor_mask_t here_mask;
    // Floors whose buttons may light up this cycle
    floor_mask_t set_gate;
    // Floors whose lights go dark this cycle
    floor_mask_t clear_mask;

    floor_mask_t call_next;
    floor_mask_t panel_next;

    //////////////////////////////////////////////////
    // Per floor set and clear masks
    //////////////////////////////////////////////////

    assign here_mask = floor_mask_t'(1) << status.current_floor;

    // Pressing the button of the floor the car sits at does nothing
    assign set_gate = status.requests_enabled ? ~here_mask : '0;

    // Arrival clears the hall and the car light together
    assign clear_mask = status.stopped ? here_mask : '0;

    // Shared update rule for both button panels, clear beats set
    function automatic floor_mask_t next_lights(
        input floor_mask_t lights,
        input floor_mask_t buttons,
        input floor_mask_t gate,
        input floor_mask_t clear
    );
        floor_mask_t set_mask;
        set_mask = buttons & gate;
        return (lights | set_mask) & ~clear;
    endfunction

    assign call_next  = next_lights(call_button_lights, floor_call_buttons,
                                    set_gate, clear_mask);
    assign panel_next = next_lights(panel_button_lights, panel_buttons,
                                    set_gate, clear_mask);

    //////////////////////////////////////////////////
    // Request lights
    //////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            call_button_lights  <= '0;
            panel_button_lights <= '0;
        end else begin
            call_button_lights  <= call_next;
            panel_button_lights <= panel_next;
        end
    end

endmodule

// File: design/dispatch_scheduler.sv
`include "elevator_consts.svh"

module dispatch_scheduler (
    input  logic                       clock,
    input  logic                       reset_n,
    car_status_if.dispatch_sink        status,
    input  elevator_pkg::floor_mask_t  call_button_lights,
    input  elevator_pkg::floor_mask_t  panel_button_lights,
    input  logic                       car_ready,
    output logic                       activate_elevator,
    output elevator_pkg::floor_t       elevator_floor_selector,
    output elevator_pkg::direction_t   direction_selector
);
    import elevator_pkg::*;

    floor_mask_t pending;
    floor_mask_t above_mask;
    floor_mask_t below_mask;
    logic        has_above;
    logic        has_below;
    floor_t      lowest_above;
    floor_t      highest_below;
    floor_t      next_target;
    direction_t  next_dir;
    logic        transfer;

    //////////////////////////////////////////////////
    // Request search around the car
    //////////////////////////////////////////////////

    // Hall and car requests are served alike
    assign pending = call_button_lights | panel_button_lights;

    always_comb begin
        above_mask = '0;
        below_mask = '0;
        for (int i = 0; i < `NUM_FLOORS; i++) begin
            above_mask[i] = pending[i] && (floor_t'(i) > status.current_floor);
            below_mask[i] = pending[i] && (floor_t'(i) < status.current_floor);
        end
    end

    assign has_above = |above_mask;
    assign has_below = |below_mask;

    // Nearest request on each side of the car
    always_comb begin
        lowest_above  = '0;
        highest_below = '0;
        for (int i = `NUM_FLOORS - 1; i >= 0; i--) begin
            if (above_mask[i])
                lowest_above = floor_t'(i);
        end
        for (int i = 0; i < `NUM_FLOORS; i++) begin
            if (below_mask[i])
                highest_below = floor_t'(i);
        end
    end

    //////////////////////////////////////////////////
    // Direction preserving choice
    //////////////////////////////////////////////////

    // Keep going the same way while requests remain on that side
    always_comb begin
        next_target = elevator_floor_selector;
        next_dir    = direction_selector;
        if (direction_selector == DIR_UP) begin
            if (has_above) begin
                next_target = lowest_above;
                next_dir    = DIR_UP;
            end else if (has_below) begin
                next_target = highest_below;
                next_dir    = DIR_DOWN;
            end
        end else begin
            if (has_below) begin
                next_target = highest_below;
                next_dir    = DIR_DOWN;
            end else if (has_above) begin
                next_target = lowest_above;
                next_dir    = DIR_UP;
            end
        end
    end

    //////////////////////////////////////////////////
    // Command to the car FSM
    //////////////////////////////////////////////////

    assign transfer = activate_elevator && car_ready;

    // Target and direction stay frozen while the command waits
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            activate_elevator       <= 1'b0;
            elevator_floor_selector <= '0;
            direction_selector      <= `RESET_DIR_UP ? DIR_UP : DIR_DOWN;
        end else if (activate_elevator) begin
            // Withdrawn on power loss, emergency or motion
            if (transfer || !status.dispatch_enabled)
                activate_elevator <= 1'b0;
        end else if (status.dispatch_enabled && (has_above || has_below)) begin
            activate_elevator       <= 1'b1;
            elevator_floor_selector <= next_target;
            direction_selector      <= next_dir;
        end
    end

endmodule

// File: design/floor_logic_control_unit.sv
module floor_logic_control_unit (
    input  logic                       clock,
    input  logic                       reset_n,
    input  elevator_pkg::floor_mask_t  floor_call_buttons,
    input  elevator_pkg::floor_mask_t  panel_buttons,
    input  logic                       door_open_btn,
    input  logic                       door_close_btn,
    input  logic                       emergency_btn,
    input  logic                       power_switch,
    input  elevator_pkg::floor_t       current_floor_state,
    input  logic                       elevator_moving,
    input  logic                       car_ready,
    output elevator_pkg::floor_t       elevator_floor_selector,
    output elevator_pkg::direction_t   direction_selector,
    output logic                       activate_elevator,
    output elevator_pkg::floor_mask_t  call_button_lights,
    output elevator_pkg::floor_mask_t  panel_button_lights,
    output logic                       door_open_allowed,
    output logic                       door_close_allowed
);

    // Gated car status shared by the request and dispatch logic
    car_status_if status_bus ();

    //////////////////////////////////////////////////
    // Power, emergency and door handling
    //////////////////////////////////////////////////

    service_gate service_gate_i (
        .clock              (clock),
        .reset_n            (reset_n),
        .power_switch       (power_switch),
        .emergency_btn      (emergency_btn),
        .elevator_moving    (elevator_moving),
        .door_open_btn      (door_open_btn),
        .door_close_btn     (door_close_btn),
        .current_floor      (current_floor_state),
        .status             (status_bus.source),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

    //////////////////////////////////////////////////
    // Button lights
    //////////////////////////////////////////////////

    floor_request_latch floor_request_latch_i (
        .clock               (clock),
        .reset_n             (reset_n),
        .status              (status_bus.request_sink),
        .floor_call_buttons  (floor_call_buttons),
        .panel_buttons       (panel_buttons),
        .call_button_lights  (call_button_lights),
        .panel_button_lights (panel_button_lights)
    );

    //////////////////////////////////////////////////
    // Target selection and car command
    //////////////////////////////////////////////////

    dispatch_scheduler dispatch_scheduler_i (
        .clock                   (clock),
        .reset_n                 (reset_n),
        .status                  (status_bus.dispatch_sink),
        .call_button_lights      (call_button_lights),
        .panel_button_lights     (panel_button_lights),
        .car_ready               (car_ready),
        .activate_elevator       (activate_elevator),
        .elevator_floor_selector (elevator_floor_selector),
        .direction_selector      (direction_selector)
    );

endmodule

// File: tests/tb_floor_logic.sv
`include "elevator_consts.svh"

module tb_floor_logic;
    timeunit 1ns;
    timeprecision 1ps;

    import elevator_pkg::*;

    localparam int          RESET_CYCLES   = 8;
    localparam int          RANDOM_CYCLES  = 3000;
    // Random phase with a wide margin that also covers reset
    localparam int          TIMEOUT_CYCLES = 5 * RANDOM_CYCLES / 3;
    localparam logic [31:0] SEED           = 32'hd311_da8c;

    logic        clock;
    logic        reset_n;
    floor_mask_t floor_call_buttons;
    floor_mask_t panel_buttons;
    logic        door_open_btn;
    logic        door_close_btn;
    logic        emergency_btn;
    logic        power_switch;
    floor_t      current_floor_state;
    logic        elevator_moving;
    logic        car_ready;
    floor_t      elevator_floor_selector;
    direction_t  direction_selector;
    logic        activate_elevator;
    floor_mask_t call_button_lights;
    floor_mask_t panel_button_lights;
    logic        door_open_allowed;
    logic        door_close_allowed;

    // Reference model state updated at each rising edge
    floor_mask_t exp_call;
    floor_mask_t exp_panel;
    logic        exp_valid;
    floor_t      exp_target;
    direction_t  exp_dir;
    logic        exp_door_open;
    logic        exp_door_close;
    logic        edge_xfer;
    logic        edge_req_en;
    floor_t      xfer_target;
    direction_t  xfer_dir;

    // DUT outputs seen at the previous falling edge
    logic        hold_valid;
    logic        hold_ready;
    floor_t      hold_target;
    direction_t  hold_dir;
    floor_mask_t prev_call;
    floor_mask_t prev_panel;

    floor_t      car_target;
    int          step_timer;
    logic [31:0] rng;
    int          errors;
    int          transfers;
    int          cycle_count;

    floor_logic_control_unit dut_i (
        .clock                   (clock),
        .reset_n                 (reset_n),
        .floor_call_buttons      (floor_call_buttons),
        .panel_buttons           (panel_buttons),
        .door_open_btn           (door_open_btn),
        .door_close_btn          (door_close_btn),
        .emergency_btn           (emergency_btn),
        .power_switch            (power_switch),
        .current_floor_state     (current_floor_state),
        .elevator_moving         (elevator_moving),
        .car_ready               (car_ready),
        .elevator_floor_selector (elevator_floor_selector),
        .direction_selector      (direction_selector),
        .activate_elevator       (activate_elevator),
        .call_button_lights      (call_button_lights),
        .panel_button_lights     (panel_button_lights),
        .door_open_allowed       (door_open_allowed),
        .door_close_allowed      (door_close_allowed)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    //////////////////////////////////////////////////
    // Random numbers
    //////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] draw();
        rng = xorshift32(rng);
        return rng;
    endfunction

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    // Closest lit floor above the car or -1 when none
    function automatic int nearest_above(input floor_mask_t lit, input floor_t here);
        for (int f = int'(here) + 1; f < `NUM_FLOORS; f++) begin
            if (lit[f])
                return f;
        end
        return -1;
    endfunction

    function automatic int nearest_below(input floor_mask_t lit, input floor_t here);
        for (int f = int'(here) - 1; f >= 0; f--) begin
            if (lit[f])
                return f;
        end
        return -1;
    endfunction

    always @(posedge clock) begin : model_update
        logic        req_en;
        logic        stopped;
        floor_mask_t lit;
        int          up_f;
        int          down_f;
        if (!reset_n) begin
            exp_call       = '0;
            exp_panel      = '0;
            exp_valid      = 1'b0;
            exp_target     = '0;
            exp_dir        = DIR_UP;
            exp_door_open  = 1'b0;
            exp_door_close = 1'b0;
            edge_xfer      = 1'b0;
            edge_req_en    = 1'b0;
        end else begin
            req_en      = power_switch && !emergency_btn;
            stopped     = power_switch && !elevator_moving;
            lit         = exp_call | exp_panel;
            up_f        = nearest_above(lit, current_floor_state);
            down_f      = nearest_below(lit, current_floor_state);
            edge_xfer   = exp_valid && car_ready;
            edge_req_en = req_en;
            xfer_target = exp_target;
            xfer_dir    = exp_dir;
            // Command holds until accepted or withdrawn
            if (exp_valid) begin
                if (edge_xfer || !(req_en && stopped))
                    exp_valid = 1'b0;
            end else if (req_en && stopped && (up_f >= 0 || down_f >= 0)) begin
                exp_valid = 1'b1;
                if ((exp_dir == DIR_UP && up_f >= 0) || down_f < 0) begin
                    exp_target = floor_t'(up_f);
                    exp_dir    = DIR_UP;
                end else begin
                    exp_target = floor_t'(down_f);
                    exp_dir    = DIR_DOWN;
                end
            end
            for (int f = 0; f < `NUM_FLOORS; f++) begin
                if (f == int'(current_floor_state)) begin
                    if (stopped) begin
                        exp_call[f]  = 1'b0;
                        exp_panel[f] = 1'b0;
                    end
                end else if (req_en) begin
                    exp_call[f]  = exp_call[f] | floor_call_buttons[f];
                    exp_panel[f] = exp_panel[f] | panel_buttons[f];
                end
            end
            exp_door_open  = stopped && door_open_btn;
            exp_door_close = stopped && door_close_btn && !door_open_btn;
        end
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    task automatic report_mismatch(input string what, input int got, input int want);
        $display("MISMATCH at %0d ns: %s is %0h, expected %0h", $time, what, got, want);
        errors++;
    endtask

    task automatic check_reset_values();
        if (activate_elevator !== 1'b0)
            report_mismatch("activate_elevator in reset", int'(activate_elevator), 0);
        if (call_button_lights !== '0 || panel_button_lights !== '0)
            report_mismatch("lights in reset", int'(call_button_lights | panel_button_lights), 0);
        if (door_open_allowed !== 1'b0 || door_close_allowed !== 1'b0)
            report_mismatch("door permits in reset", int'(door_open_allowed), 0);
        if (elevator_floor_selector !== '0)
            report_mismatch("target in reset", int'(elevator_floor_selector), 0);
        if (direction_selector !== DIR_UP)
            report_mismatch("direction in reset", int'(direction_selector), int'(DIR_UP));
    endtask

    task automatic check_outputs();
        if (call_button_lights !== exp_call)
            report_mismatch("call lights", int'(call_button_lights), int'(exp_call));
        if (panel_button_lights !== exp_panel)
            report_mismatch("panel lights", int'(panel_button_lights), int'(exp_panel));
        if (activate_elevator !== exp_valid)
            report_mismatch("activate_elevator", int'(activate_elevator), int'(exp_valid));
        if (elevator_floor_selector !== exp_target)
            report_mismatch("target floor", int'(elevator_floor_selector), int'(exp_target));
        if (direction_selector !== exp_dir)
            report_mismatch("direction", int'(direction_selector), int'(exp_dir));
        if (door_open_allowed !== exp_door_open)
            report_mismatch("door open permit", int'(door_open_allowed), int'(exp_door_open));
        if (door_close_allowed !== exp_door_close)
            report_mismatch("door close permit", int'(door_close_allowed),
                            int'(exp_door_close));
        // Back pressure keeps the command frozen
        if (hold_valid && !hold_ready && activate_elevator) begin
            if (elevator_floor_selector !== hold_target || direction_selector !== hold_dir)
                report_mismatch("held target", int'(elevator_floor_selector), int'(hold_target));
        end
        if (!edge_req_en) begin
            if (((call_button_lights & ~prev_call) | (panel_button_lights & ~prev_panel)) != '0)
                report_mismatch("lights set while gated", int'(call_button_lights), int'(prev_call));
            if (activate_elevator)
                report_mismatch("activate while gated", 1, 0);
        end
        if (edge_xfer) begin
            transfers++;
            if (hold_target !== xfer_target || hold_dir !== xfer_dir)
                report_mismatch("transferred target", int'(hold_target), int'(xfer_target));
        end
    endtask

    //////////////////////////////////////////////////
    // Car model and stimulus
    //////////////////////////////////////////////////

    task automatic step_car();
        if (edge_xfer) begin
            car_target      = xfer_target;
            elevator_moving = 1'b1;
            step_timer      = 2 + int'(draw() % 5);
        end else if (elevator_moving) begin
            step_timer--;
            if (step_timer == 0) begin
                if (current_floor_state < car_target)
                    current_floor_state = current_floor_state + 1'b1;
                else
                    current_floor_state = current_floor_state - 1'b1;
                if (current_floor_state == car_target)
                    elevator_moving = 1'b0;
                else
                    step_timer = 2 + int'(draw() % 5);
            end
        end
    endtask

    task automatic drive_inputs();
        logic [31:0] r;
        r = draw();
        floor_call_buttons = '0;
        panel_buttons      = '0;
        if (r[2:0] == 3'd0)
            floor_call_buttons = floor_mask_t'(1) << (draw() % `NUM_FLOORS);
        if (r[5:3] == 3'd0)
            panel_buttons = floor_mask_t'(1) << (draw() % `NUM_FLOORS);
        door_open_btn  = (r[8:6] == 3'd0);
        door_close_btn = (r[11:9] < 3'd2);
        power_switch   = (r[17:12] >= 6'd3);
        emergency_btn  = (r[23:18] < 6'd2);
        car_ready      = r[24];
    endtask

    task automatic record_outputs();
        hold_valid  = activate_elevator;
        hold_ready  = car_ready;
        hold_target = elevator_floor_selector;
        hold_dir    = direction_selector;
        prev_call   = call_button_lights;
        prev_panel  = panel_button_lights;
    endtask

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin
        rng                 = SEED;
        errors              = 0;
        transfers           = 0;
        cycle_count         = 0;
        reset_n             = 1'b0;
        floor_call_buttons  = '0;
        panel_buttons       = '0;
        door_open_btn       = 1'b0;
        door_close_btn      = 1'b0;
        emergency_btn       = 1'b0;
        power_switch        = 1'b1;
        current_floor_state = '0;
        elevator_moving     = 1'b0;
        car_ready           = 1'b0;
        car_target          = '0;
        step_timer          = 0;
        hold_valid          = 1'b0;
        hold_ready          = 1'b0;
        hold_target         = '0;
        hold_dir            = DIR_UP;
        prev_call           = '0;
        prev_panel          = '0;
        repeat (RESET_CYCLES) @(negedge clock);
        check_reset_values();
        reset_n = 1'b1;
        for (int c = 0; c < RANDOM_CYCLES; c++) begin
            @(negedge clock);
            check_outputs();
            step_car();
            drive_inputs();
            record_outputs();
        end
        $display("Run done: %0d cycles, %0d transfers, %0d errors",
                 RANDOM_CYCLES, transfers, errors);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

// File: tb.f
+incdir+design
design/elevator_pkg.sv
design/car_status_if.sv
design/service_gate.sv
design/floor_request_latch.sv
design/dispatch_scheduler.sv
design/floor_logic_control_unit.sv
tests/tb_floor_logic.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the floor logic testbench with Verilator and runs it

set -u

cd "$(dirname "$0")" || exit 1

TOP=tb_floor_logic
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing \
    --timescale 1ns/1ps \
    --top-module "$TOP" \
    -Mdir "$BUILD_DIR" \
    -o "$TOP" \
    -f tb.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# The verdict comes from the log
if grep -qx "ALL CHECKS PASSED" "$LOG"; then
    echo "Result: pass"
    exit 0
else
    echo "Result: fail"
    exit 1
fi
